//--- hdl/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // ====================
    // Address map
    // ====================

    localparam int TIMER_COUNT    = 4;
    localparam int REG_PER_DEVICE = 4;

    // Word registers above the two byte-offset bits
    localparam int DEV_SEL_LSB = $clog2(REG_PER_DEVICE) + 2;
    localparam int DEV_IDX_W   = $clog2(TIMER_COUNT);

    // Timers first, bus error on top
    localparam int INT_SOURCES = TIMER_COUNT + 1;
    localparam int INT_VEC_W   = $clog2(INT_SOURCES);

    // ====================
    // Basic types
    // ====================

    typedef logic [31:0]          data_t;
    typedef logic [31:0]          addr_t;
    typedef logic [3:0]           strobe_t;
    typedef logic [1:0]           reg_idx_t;
    typedef logic [INT_VEC_W-1:0] int_vec_t;

    // Index 3 is reserved
    localparam reg_idx_t REG_VALUE   = 2'd0;
    localparam reg_idx_t REG_COMPARE = 2'd1;
    localparam reg_idx_t REG_CONTROL = 2'd2;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } access_width_e;

    // ====================
    // Bus structs
    // ====================

    typedef struct packed {
        logic          write;
        logic          read;
        addr_t         address;
        data_t         data;
        access_width_e width;
    } mmio_req_t;

    typedef struct packed {
        logic  done;
        logic  error;
        data_t data;
    } mmio_rsp_t;

    typedef struct packed {
        logic     write;
        logic     read;
        reg_idx_t reg_idx;
        data_t    data;
        strobe_t  strobe;
    } dev_req_t;

endpackage : mmio_pkg

`default_nettype wire

//--- hdl/mmio_decoder.sv
`default_nettype none

module mmio_decoder (
    input  wire                                           sys_clk,
    input  wire                                           rst_n_i,

    // CPU side
    input  wire mmio_pkg::mmio_req_t                      req_i,
    output mmio_pkg::mmio_rsp_t                           rsp_o,

    // Device side
    output mmio_pkg::dev_req_t                            dev_req_o,
    output logic [mmio_pkg::TIMER_COUNT-1:0]              timer_sel_o,
    input  wire mmio_pkg::data_t [mmio_pkg::TIMER_COUNT-1:0] dev_rdata_i,

    output logic                                          bus_error_o
);

    import mmio_pkg::*;

    logic                 access;
    logic                 dev_mapped;
    logic                 reg_mapped;
    logic                 hit;
    logic [DEV_IDX_W-1:0] dev_idx;
    reg_idx_t             reg_idx;
    strobe_t              strobe;

    // ====================
    // Address split
    // ====================

    assign access  = req_i.write | req_i.read;
    assign dev_idx = req_i.address[DEV_SEL_LSB +: DEV_IDX_W];
    assign reg_idx = req_i.address[3:2];

    // Whole upper field is checked, not just the index bits
    assign dev_mapped = (req_i.address >> DEV_SEL_LSB) < addr_t'(TIMER_COUNT);
    assign reg_mapped = reg_idx <= REG_CONTROL;
    assign hit        = access & dev_mapped & reg_mapped;

    // Byte lanes from access width
    always_comb begin
        case (req_i.width)
            WORD:      strobe = 4'b1111;
            HALF_WORD: strobe = 4'b0011 << {req_i.address[1], 1'b0};
            BYTE:      strobe = 4'b0001 << req_i.address[1:0];
            default:   strobe = '0;
        endcase
    end

    // Broadcast request, one-hot select
    always_comb begin
        dev_req_o.write   = req_i.write;
        dev_req_o.read    = req_i.read;
        dev_req_o.reg_idx = reg_idx;
        dev_req_o.data    = req_i.data;
        dev_req_o.strobe  = strobe;

        for (int i = 0; i < TIMER_COUNT; i++) begin
            timer_sel_o[i] = hit & (dev_idx == DEV_IDX_W'(i));
        end
    end

    // ====================
    // Response
    // ====================

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_o <= '0;
        end else begin
            rsp_o.done  <= access;
            rsp_o.error <= access & !(dev_mapped & reg_mapped);

            if (hit & req_i.read) begin
                rsp_o.data <= dev_rdata_i[dev_idx];
            end else begin
                rsp_o.data <= '0;
            end
        end
    end

    // Error pulse lines up with done
    assign bus_error_o = rsp_o.error;

endmodule : mmio_decoder

`default_nettype wire

//--- hdl/timer_device.sv
`default_nettype none

module timer_device (
    input  wire                     sys_clk,
    input  wire                     rst_n_i,

    input  wire mmio_pkg::dev_req_t dev_req_i,
    input  wire                     sel_i,
    output mmio_pkg::data_t         rdata_o,

    output logic                    fire_o
);

    import mmio_pkg::*;

    data_t value_q;
    data_t compare_q;
    logic  enable_q;
    logic  wr_en;
    logic  match;

    // Merge write data into a word, lane by lane
    function automatic data_t merge_bytes(
        input data_t   old_word,
        input data_t   new_word,
        input strobe_t strb
    );
        data_t merged;

        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign wr_en = sel_i & dev_req_i.write;
    assign match = enable_q & (value_q == compare_q);

    // ====================
    // Counter and registers
    // ====================

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            value_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            fire_o    <= 1'b0;
        end else begin
            fire_o <= match;

            // One-shot: stop and rewind on match
            if (match) begin
                value_q  <= '0;
                enable_q <= 1'b0;
            end else if (enable_q) begin
                value_q <= value_q + 1'b1;
            end

            // Bus write has the last word
            if (wr_en) begin
                case (dev_req_i.reg_idx)
                    REG_VALUE:   value_q   <= merge_bytes(value_q, dev_req_i.data,
                                                          dev_req_i.strobe);
                    REG_COMPARE: compare_q <= merge_bytes(compare_q, dev_req_i.data,
                                                          dev_req_i.strobe);
                    REG_CONTROL: begin
                        if (dev_req_i.strobe[0]) begin
                            enable_q <= dev_req_i.data[0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read word for the addressed register
    always_comb begin
        case (dev_req_i.reg_idx)
            REG_VALUE:   rdata_o = value_q;
            REG_COMPARE: rdata_o = compare_q;
            REG_CONTROL: rdata_o = {31'b0, enable_q};
            default:     rdata_o = '0;
        endcase
    end

endmodule : timer_device

`default_nettype wire

//--- hdl/interrupt_controller.sv
`default_nettype none

module interrupt_controller (
    input  wire                               sys_clk,
    input  wire                               rst_n_i,

    input  wire [mmio_pkg::INT_SOURCES-1:0]   source_i,

    input  wire                               ack_i,
    output logic                              irq_o,
    output mmio_pkg::int_vec_t                vector_o
);

    import mmio_pkg::*;

    logic [INT_SOURCES-1:0] pending_q;
    logic [INT_SOURCES-1:0] clear_mask;

    // ====================
    // Priority encoder
    // ====================

    // Descending scan so the lowest pending index wins
    always_comb begin
        vector_o = '0;
        for (int i = INT_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                vector_o = int_vec_t'(i);
            end
        end
    end

    assign irq_o = |pending_q;

    // Ack retires only the presented source
    always_comb begin
        clear_mask = '0;
        if (ack_i) begin
            clear_mask[vector_o] = 1'b1;
        end
    end

    // ====================
    // Pending register
    // ====================

    // A new pulse beats a same-cycle ack
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | source_i;
        end
    end

endmodule : interrupt_controller

`default_nettype wire

//--- hdl/timer_subsystem.sv
`default_nettype none

module timer_subsystem (
    input  wire                      sys_clk,
    input  wire                      rst_n_i,

    // Memory-mapped bus
    input  wire mmio_pkg::mmio_req_t req_i,
    output mmio_pkg::mmio_rsp_t      rsp_o,

    // Interrupt to the CPU
    output logic                     irq_o,
    input  wire                      irq_ack_i,
    output mmio_pkg::int_vec_t       irq_vector_o
);

    import mmio_pkg::*;

    dev_req_t                      dev_req;
    logic     [TIMER_COUNT-1:0]    timer_sel;
    data_t    [TIMER_COUNT-1:0]    timer_rdata;
    logic     [TIMER_COUNT-1:0]    timer_fire;
    logic                          bus_error;

    mmio_decoder u_decoder (
        .sys_clk     ( sys_clk     ),
        .rst_n_i     ( rst_n_i     ),
        .req_i       ( req_i       ),
        .rsp_o       ( rsp_o       ),
        .dev_req_o   ( dev_req     ),
        .timer_sel_o ( timer_sel   ),
        .dev_rdata_i ( timer_rdata ),
        .bus_error_o ( bus_error   )
    );

    // ====================
    // Timer row
    // ====================

    for (genvar i = 0; i < TIMER_COUNT; i++) begin : gen_timer
        timer_device u_timer (
            .sys_clk   ( sys_clk        ),
            .rst_n_i   ( rst_n_i        ),
            .dev_req_i ( dev_req        ),
            .sel_i     ( timer_sel[i]   ),
            .rdata_o   ( timer_rdata[i] ),
            .fire_o    ( timer_fire[i]  )
        );
    end

    // Bus error is the highest source index
    interrupt_controller u_intc (
        .sys_clk  ( sys_clk                 ),
        .rst_n_i  ( rst_n_i                 ),
        .source_i ( {bus_error, timer_fire} ),
        .ack_i    ( irq_ack_i               ),
        .irq_o    ( irq_o                   ),
        .vector_o ( irq_vector_o            )
    );

endmodule : timer_subsystem

`default_nettype wire

//--- bench/tb_timer_subsystem.sv
`default_nettype none

module tb_timer_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    import mmio_pkg::*;

    typedef struct {
        string         name;
        logic          is_write;
        addr_t         addr;
        access_width_e width;
        data_t         data;
        data_t         exp_data;
        logic          exp_err;
    } entry_t;

    logic      sys_clk = 1'b0;
    logic      rst_n_i;
    mmio_req_t req_i;
    mmio_rsp_t rsp_o;
    logic      irq_o;
    logic      irq_ack_i;
    int_vec_t  irq_vector_o;
    entry_t    table_q[$];

    timer_subsystem dut0 (
        .sys_clk      ( sys_clk      ),
        .rst_n_i      ( rst_n_i      ),
        .req_i        ( req_i        ),
        .rsp_o        ( rsp_o        ),
        .irq_o        ( irq_o        ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_vector_o ( irq_vector_o )
    );

    always #20 sys_clk = ~sys_clk;

    // ====================
    // Helpers
    // ====================

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Bytes touched by an access of the given width
    function automatic data_t lane_mask(input access_width_e width, input addr_t addr);
        case (width)
            WORD:      return 32'hffff_ffff;
            HALF_WORD: return addr[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:   return 32'hff << (8 * addr[1:0]);
        endcase
    endfunction

    function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                          input data_t mask);
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic add_entry(input string name, input logic is_write, input addr_t addr,
                             input access_width_e width, input data_t data,
                             input data_t exp_data, input logic exp_err);
        entry_t e;

        e = '{name, is_write, addr, width, data, exp_data, exp_err};
        table_q.push_back(e);
    endtask

    // One request, then wait for done
    task automatic bus_access(input addr_t addr, input logic is_write,
                              input access_width_e width, input data_t data,
                              output data_t rdata, output logic err);
        int cycles;

        cycles = 0;
        @(posedge sys_clk);
        #2;
        // Done from any earlier access is a single-cycle pulse
        check_value("done low before request", 0, rsp_o.done);
        req_i.write   = is_write;
        req_i.read    = !is_write;
        req_i.address = addr;
        req_i.data    = data;
        req_i.width   = width;
        @(posedge sys_clk);
        #2;
        req_i = '0;
        while (!rsp_o.done) begin
            if (cycles >= 20) begin
                $display("Timeout: no bus response for address %h", addr);
                stop_with_failure();
            end
            @(posedge sys_clk);
            #2;
            cycles++;
        end
        rdata = rsp_o.data;
        err   = rsp_o.error;
    endtask

    task automatic reg_write(input string name, input addr_t addr, input data_t data);
        data_t rdata;
        logic  err;

        bus_access(addr, 1'b1, WORD, data, rdata, err);
        check_value({name, " error"}, 0, err);
    endtask

    task automatic reg_read(input string name, input addr_t addr, input data_t exp);
        data_t rdata;
        logic  err;

        bus_access(addr, 1'b0, WORD, '0, rdata, err);
        check_value({name, " error"}, 0, err);
        check_value(name, exp, rdata);
    endtask

    task automatic acknowledge_irq();
        irq_ack_i = 1'b1;
        @(posedge sys_clk);
        #2;
        irq_ack_i = 1'b0;
    endtask

    task automatic wait_for_irq(input int max_cycles);
        int cycles;

        cycles = 0;
        while (!irq_o) begin
            if (cycles >= max_cycles) begin
                $display("Timeout: irq_o did not rise within %0d cycles", max_cycles);
                stop_with_failure();
            end
            @(posedge sys_clk);
            #2;
            cycles++;
        end
    endtask

    // ====================
    // Stimulus table
    // ====================

    task automatic build_table();
        data_t cmp[TIMER_COUNT];
        data_t known;
        data_t d;
        addr_t a;

        for (int i = 0; i < TIMER_COUNT; i++) begin
            for (int r = 0; r < 3; r++) begin
                add_entry($sformatf("reset t%0d r%0d", i, r), 1'b0, addr_t'(i * 16 + r * 4),
                          WORD, '0, '0, 1'b0);
            end
        end
        for (int i = 0; i < TIMER_COUNT; i++) begin
            cmp[i] = $urandom();
            a      = addr_t'(i * 16 + 4);
            add_entry($sformatf("word wr t%0d", i), 1'b1, a, WORD, cmp[i], '0, 1'b0);
            add_entry($sformatf("word rd t%0d", i), 1'b0, a, WORD, '0, cmp[i], 1'b0);
        end

        // Partial writes into a known compare word of timer 0
        known = 32'h1122_3344;
        add_entry("strobe base", 1'b1, 32'h04, WORD, known, '0, 1'b0);
        d     = $urandom();
        known = merge_lanes(known, d, lane_mask(BYTE, 32'h05));
        add_entry("byte wr", 1'b1, 32'h05, BYTE, d, '0, 1'b0);
        add_entry("byte rd", 1'b0, 32'h04, WORD, '0, known, 1'b0);
        d     = $urandom();
        known = merge_lanes(known, d, lane_mask(HALF_WORD, 32'h06));
        add_entry("half wr", 1'b1, 32'h06, HALF_WORD, d, '0, 1'b0);
        add_entry("half rd", 1'b0, 32'h04, WORD, '0, known, 1'b0);

        // Reserved register and unmapped device
        add_entry("rsvd rd", 1'b0, 32'h0c, WORD, '0, '0, 1'b1);
        add_entry("rsvd wr", 1'b1, 32'h1c, WORD, $urandom(), '0, 1'b1);
        add_entry("unmapped wr", 1'b1, addr_t'(TIMER_COUNT * 16 + 4), WORD, $urandom(), '0, 1'b1);
        add_entry("unmapped rd", 1'b0, addr_t'(TIMER_COUNT * 16 + 4), WORD, '0, '0, 1'b1);
        add_entry("intact t0", 1'b0, 32'h04, WORD, '0, known, 1'b0);
        add_entry("intact t1", 1'b0, 32'h14, WORD, '0, cmp[1], 1'b0);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int    polls;
        data_t rdata;
        logic  err;

        void'($urandom(32'hbdd7));
        rst_n_i   = 1'b0;
        req_i     = '0;
        irq_ack_i = 1'b0;
        repeat (8) @(posedge sys_clk);
        #2;
        rst_n_i = 1'b1;

        build_table();
        foreach (table_q[n]) begin
            bus_access(table_q[n].addr, table_q[n].is_write, table_q[n].width,
                       table_q[n].data, rdata, err);
            if (!table_q[n].is_write) begin
                check_value(table_q[n].name, table_q[n].exp_data, rdata);
            end
            check_value({table_q[n].name, " error"}, table_q[n].exp_err, err);
            if (table_q[n].exp_err) begin
                @(posedge sys_clk);
                #2;
                check_value({table_q[n].name, " irq"}, 1, irq_o);
                check_value({table_q[n].name, " vector"}, TIMER_COUNT, irq_vector_o);
                acknowledge_irq();
                check_value({table_q[n].name, " irq ack"}, 0, irq_o);
            end
        end

        // One-shot on timer 2
        reg_write("t2 compare", 32'h24, 32'd10);
        reg_write("t2 value", 32'h20, 32'd0);
        reg_write("t2 enable", 32'h28, 32'd1);
        wait_for_irq(100);
        check_value("one-shot vector", 2, irq_vector_o);
        reg_read("one-shot control", 32'h28, 32'd0);
        acknowledge_irq();
        repeat (30) begin
            check_value("one-shot quiet", 0, irq_o);
            @(posedge sys_clk);
            #2;
        end

        // Timer 3 fires first, timer 1 must still win
        reg_write("t3 compare", 32'h34, 32'd5);
        reg_write("t1 compare", 32'h14, 32'd40);
        reg_write("t3 enable", 32'h38, 32'd1);
        reg_write("t1 enable", 32'h18, 32'd1);
        polls = 0;
        do begin
            if (polls >= 50) begin
                $display("Timeout: timer 1 enable never cleared");
                stop_with_failure();
            end
            bus_access(32'h18, 1'b0, WORD, '0, rdata, err);
            polls++;
        end while (rdata != 0);
        check_value("priority first", 1, irq_vector_o);
        acknowledge_irq();
        check_value("priority second", 3, irq_vector_o);
        acknowledge_irq();
        check_value("priority done", 0, irq_o);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_timer_subsystem

`default_nettype wire

//--- flist.f
hdl/mmio_pkg.sv
hdl/mmio_decoder.sv
hdl/timer_device.sv
hdl/interrupt_controller.sv
hdl/timer_subsystem.sv
bench/tb_timer_subsystem.sv

//--- Bender.yml
package:
  name: timer_subsystem

sources:
  # Package first, then leaf modules, then the top
  - hdl/mmio_pkg.sv
  - hdl/mmio_decoder.sv
  - hdl/timer_device.sv
  - hdl/interrupt_controller.sv
  - hdl/timer_subsystem.sv

  - target: test
    files:
      - bench/tb_timer_subsystem.sv
